// File: rtl/lsu.sv
`timescale 1ns/1ps

module lsu (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  output logic               req_ready,
  input  lsu_pkg::lsu_req_t  req,
  output logic               resp_valid,
  output lsu_pkg::lsu_resp_t resp,
  output lsu_pkg::bus_ar_t   ar,
  output logic               ar_valid,
  input  logic               ar_ready,
  input  lsu_pkg::bus_r_t    r,
  input  logic               r_valid,
  output logic               r_ready,
  output lsu_pkg::bus_aw_t   aw,
  output logic               aw_valid,
  input  logic               aw_ready,
  output lsu_pkg::bus_w_t    w,
  output logic               w_valid,
  input  logic               w_ready,
  input  logic               b_valid,
  output logic               b_ready
);

  import lsu_pkg::*;

  lsu_req_t    req_q;
  logic        busy;
  logic        accept;
  logic        start_q;
  logic        done;
  logic [31:0] bm_rdata;
  logic [31:0] lane_data;
  logic [3:0]  lane_strb;
  logic [31:0] load_data;

  assign req_ready = !busy;
  assign accept    = req_valid && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      start_q    <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      start_q    <= accept;
      resp_valid <= done;
      if (accept) busy <= 1'b1;
      else if (done) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) req_q <= req;
    if (done) begin
      resp.op    <= req_q.op;
      resp.rdata <= (req_q.op == LSU_LOAD) ? load_data : 32'h0;
    end
  end

  lsu_lane_align u_align (
    .size       (req_q.size),
    .sign       (req_q.sign),
    .offset     (req_q.addr[1:0]),
    .store_data (req_q.wdata),
    .lane_data  (lane_data),
    .lane_strb  (lane_strb),
    .word_in    (bm_rdata),
    .load_data  (load_data)
  );

  lsu_bus_master u_master (
    .clk      (clk),
    .rst      (rst),
    .start    (start_q),
    .op       (req_q.op),
    .addr     ({req_q.addr[31:2], 2'b00}),  // word aligned.
    .data     (lane_data),
    .strb     (lane_strb),
    .done     (done),
    .rdata    (bm_rdata),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b_ready  (b_ready)
  );

endmodule

// File: rtl/lsu_bus_master.sv
`timescale 1ns/1ps

module lsu_bus_master (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  lsu_pkg::lsu_op_e  op,
  input  logic [31:0]       addr,
  input  logic [31:0]       data,
  input  logic [3:0]        strb,
  output logic              done,
  output logic [31:0]       rdata,
  output lsu_pkg::bus_ar_t  ar,
  output logic              ar_valid,
  input  logic              ar_ready,
  input  lsu_pkg::bus_r_t   r,
  input  logic              r_valid,
  output logic              r_ready,
  output lsu_pkg::bus_aw_t  aw,
  output logic              aw_valid,
  input  logic              aw_ready,
  output lsu_pkg::bus_w_t   w,
  output logic              w_valid,
  input  logic              w_ready,
  input  logic              b_valid,
  output logic              b_ready
);

  import lsu_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ_ADDR,
    READ_DATA,
    WRITE_REQ,
    WRITE_RESP
  } state_e;

  state_e      state;
  logic [31:0] rdata_q;
  logic        r_fire;
  logic        b_fire;
  logic        aw_left;
  logic        w_left;

  assign r_ready = (state == READ_DATA);
  assign b_ready = (state == WRITE_RESP);
  assign r_fire  = r_valid && r_ready;
  assign b_fire  = b_valid && b_ready;

  // beats still owed after this edge.
  assign aw_left = aw_valid && !aw_ready;
  assign w_left  = w_valid && !w_ready;

  assign done  = r_fire || b_fire;
  assign rdata = r_fire ? r.data : rdata_q;  // fresh beat bypasses the capture reg.

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      ar_valid <= 1'b0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            if (op == LSU_LOAD) begin
              ar_valid <= 1'b1;
              state    <= READ_ADDR;
            end else begin
              aw_valid <= 1'b1;
              w_valid  <= 1'b1;
              state    <= WRITE_REQ;
            end
          end
        end
        READ_ADDR: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            state    <= READ_DATA;
          end
        end
        READ_DATA: begin
          if (r_fire) state <= IDLE;
        end
        WRITE_REQ: begin
          if (aw_valid && aw_ready) aw_valid <= 1'b0;
          if (w_valid && w_ready) w_valid <= 1'b0;
          if (!aw_left && !w_left) state <= WRITE_RESP;
        end
        WRITE_RESP: begin
          if (b_fire) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // payload held stable while valid is up.
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      ar.addr <= addr;
      aw.addr <= addr;
      w.data  <= data;
      w.strb  <= strb;
    end
    if (r_fire) rdata_q <= r.data;
  end

endmodule

// File: rtl/lsu_lane_align.sv
`timescale 1ns/1ps

module lsu_lane_align (
  input  lsu_pkg::lsu_size_e size,
  input  logic               sign,
  input  logic [1:0]         offset,
  input  logic [31:0]        store_data,
  output logic [31:0]        lane_data,
  output logic [3:0]         lane_strb,
  input  logic [31:0]        word_in,
  output logic [31:0]        load_data
);

  import lsu_pkg::*;

  logic [31:0] shifted;

  // store side: replicate so every lane carries the value.
  always_comb begin
    case (size)
      SIZE_BYTE: begin
        lane_data = {4{store_data[7:0]}};
        lane_strb = 4'b0001 << offset;
      end
      SIZE_HALF: begin
        lane_data = {2{store_data[15:0]}};
        lane_strb = 4'b0011 << {offset[1], 1'b0};
      end
      default: begin
        lane_data = store_data;
        lane_strb = 4'b1111;
      end
    endcase
  end

  assign shifted = word_in >> {offset, 3'b000};

  always_comb begin
    case (size)
      SIZE_BYTE: load_data = {{24{sign & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: load_data = {{16{sign & shifted[15]}}, shifted[15:0]};
      default:   load_data = shifted;  // word, offset is zero.
    endcase
  end

endmodule

// File: rtl/lsu_mem_slave.sv
`timescale 1ns/1ps

module lsu_mem_slave #(
  parameter int unsigned MEM_WORDS   = lsu_pkg::MEM_WORDS_DEF,
  parameter int unsigned WAIT_CYCLES = lsu_pkg::WAIT_CYCLES_DEF
) (
  input  logic             clk,
  input  logic             rst,
  input  lsu_pkg::bus_ar_t ar,
  input  logic             ar_valid,
  output logic             ar_ready,
  output lsu_pkg::bus_r_t  r,
  output logic             r_valid,
  input  logic             r_ready,
  input  lsu_pkg::bus_aw_t aw,
  input  logic             aw_valid,
  output logic             aw_ready,
  input  lsu_pkg::bus_w_t  w,
  input  logic             w_valid,
  output logic             w_ready,
  output logic             b_valid,
  input  logic             b_ready
);

  localparam int IW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CW = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  logic [31:0]   mem [MEM_WORDS];
  logic [CW-1:0] wait_cnt;
  logic          wait_done;
  logic          aw_got;
  logic          w_got;
  logic [31:0]   aw_addr_q;
  logic [35:0]   w_q;
  logic [31:0]   wr_addr;
  logic [35:0]   wr_beat;
  logic          ar_fire;
  logic          aw_fire;
  logic          w_fire;
  logic          wr_fire;
  logic          rd_pend;
  logic          wr_pend;

  // wraps on the word address.
  function automatic logic [IW-1:0] word_index(input logic [31:0] a);
    return IW'((a >> 2) % MEM_WORDS);
  endfunction

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = '0;
  end

  assign wait_done = (wait_cnt == CW'(WAIT_CYCLES));

  assign rd_pend = ar_valid && !r_valid;
  assign wr_pend = ((aw_valid && !aw_got) || (w_valid && !w_got)) && !b_valid;

  assign ar_ready = rd_pend && wait_done;
  assign aw_ready = aw_valid && !aw_got && !b_valid && wait_done;
  assign w_ready  = w_valid && !w_got && !b_valid && wait_done;

  assign ar_fire = ar_valid && ar_ready;
  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;
  // last of aw/w lands this edge.
  assign wr_fire = (aw_fire || w_fire) && (aw_got || aw_fire) && (w_got || w_fire);

  assign wr_addr = aw_fire ? aw.addr : aw_addr_q;
  assign wr_beat = w_fire ? w : w_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      r_valid  <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      if (ar_fire || wr_fire) wait_cnt <= '0;
      else if ((rd_pend || wr_pend) && !wait_done) wait_cnt <= wait_cnt + 1'b1;

      if (wr_fire) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end else begin
        if (aw_fire) aw_got <= 1'b1;
        if (w_fire) w_got <= 1'b1;
      end

      if (ar_fire) r_valid <= 1'b1;
      else if (r_ready) r_valid <= 1'b0;

      if (wr_fire) b_valid <= 1'b1;
      else if (b_ready) b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) aw_addr_q <= aw.addr;
    if (w_fire) w_q <= w;
    if (ar_fire) r.data <= mem[word_index(ar.addr)];
    if (wr_fire) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_beat[i]) mem[word_index(wr_addr)][8*i +: 8] <= wr_beat[4 + 8*i +: 8];
      end
    end
  end

endmodule

// File: rtl/lsu_pkg.sv
package lsu_pkg;

  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  typedef struct packed {
    lsu_op_e     op;
    lsu_size_e   size;
    logic        sign;   // sign-extend on load.
    logic [31:0] addr;
    logic [31:0] wdata;  // low bytes used for byte/half.
  } lsu_req_t;

  typedef struct packed {
    lsu_op_e     op;
    logic [31:0] rdata;  // zero for stores.
  } lsu_resp_t;

  typedef struct packed {
    logic [31:0] addr;
  } bus_ar_t;

  typedef struct packed {
    logic [31:0] addr;
  } bus_aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } bus_w_t;

  typedef struct packed {
    logic [31:0] data;
  } bus_r_t;

  localparam int unsigned MEM_WORDS_DEF   = 1024;
  localparam int unsigned WAIT_CYCLES_DEF = 2;

endpackage

// File: rtl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned MEM_WORDS   = lsu_pkg::MEM_WORDS_DEF,
  parameter int unsigned WAIT_CYCLES = lsu_pkg::WAIT_CYCLES_DEF
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  output logic               req_ready,
  input  lsu_pkg::lsu_req_t  req,
  output logic               resp_valid,
  output lsu_pkg::lsu_resp_t resp
);

  import lsu_pkg::*;

  bus_ar_t ar;
  bus_r_t  r;
  bus_aw_t aw;
  bus_w_t  w;
  logic    ar_valid, ar_ready;
  logic    r_valid, r_ready;
  logic    aw_valid, aw_ready;
  logic    w_valid, w_ready;
  logic    b_valid, b_ready;

  lsu u_lsu (
    .clk(clk), .rst(rst),
    .req_valid(req_valid), .req_ready(req_ready), .req(req),
    .resp_valid(resp_valid), .resp(resp),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready),
    .b_valid(b_valid), .b_ready(b_ready)
  );

  lsu_mem_slave #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_mem (
    .clk(clk), .rst(rst),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready),
    .b_valid(b_valid), .b_ready(b_ready)
  );

endmodule

// File: src.f
rtl/lsu_pkg.sv
rtl/lsu_lane_align.sv
rtl/lsu_bus_master.sv
rtl/lsu_mem_slave.sv
rtl/lsu.sv
rtl/lsu_top.sv
verif/lsu_tb.sv

// File: verif/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int unsigned MEM_WORDS     = 256;
  localparam int unsigned WAIT_CYCLES   = 2;
  localparam int          DIRECTED_REQS = 35;
  localparam int          RAND_REQS     = 300;
  localparam int          WATCHDOG_NS   = (DIRECTED_REQS + RAND_REQS) * 200 + 1000;

  logic        clk = 1'b0;
  logic        rst;
  logic        req_valid;
  logic        req_ready;
  lsu_req_t    req;
  logic        resp_valid;
  lsu_resp_t   resp;

  logic [7:0]  ref_mem [MEM_WORDS*4];  // byte-wise mirror of the slave.
  lsu_resp_t   exp_q [$];
  lsu_resp_t   exp_resp;
  logic [31:0] lcg_state;
  int          n_checks;
  int          n_errors;
  int          n_resp;

  lsu_top #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) dut0 (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic lsu_req_t make_req(input lsu_op_e op, input lsu_size_e size,
                                        input logic sign, input logic [31:0] addr,
                                        input logic [31:0] wdata);
    lsu_req_t q;
    q.op    = op;
    q.size  = size;
    q.sign  = sign;
    q.addr  = addr;
    q.wdata = wdata;
    return q;
  endfunction

  // expected response; stores also update the mirror.
  function automatic lsu_resp_t ref_access(input lsu_req_t q);
    lsu_resp_t   res;
    int unsigned base;
    int          nbytes;
    int          i;
    logic [31:0] val;
    base   = ((q.addr >> 2) % MEM_WORDS) * 4 + q.addr[1:0];
    nbytes = (q.size == SIZE_BYTE) ? 1 : (q.size == SIZE_HALF) ? 2 : 4;
    val    = '0;
    for (i = 0; i < nbytes; i++) begin
      if (q.op == LSU_STORE) ref_mem[base + i] = q.wdata[8*i +: 8];
      else val[8*i +: 8] = ref_mem[base + i];
    end
    if (q.op == LSU_LOAD && q.sign && val[8*nbytes-1]) begin
      for (i = nbytes; i < 4; i++) val[8*i +: 8] = 8'hff;
    end
    res.op    = q.op;
    res.rdata = (q.op == LSU_LOAD) ? val : 32'h0;
    return res;
  endfunction

  task automatic check_resp(input lsu_resp_t got, input lsu_resp_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t %s: got op %0d rdata %h, expected op %0d rdata %h",
               $time, what, got.op, got.rdata, exp.op, exp.rdata);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // call at the drive slot; returns at the drive slot after the transfer.
  task automatic send_req(input lsu_req_t q);
    req       = q;
    req_valid = 1'b1;
    do @(negedge clk); while (!req_ready);
    @(posedge clk);
    #2;
  endtask

  task automatic wait_resp();
    do @(negedge clk); while (!resp_valid);
    @(posedge clk);
    #2;
  endtask

  task automatic run_req(input lsu_req_t q);
    send_req(q);
    req_valid = 1'b0;
    wait_resp();
  endtask

  task automatic report_test(input string name, input int err_mark);
    if (n_errors == err_mark) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, n_errors - err_mark);
  endtask

  // compare process samples mid-cycle.
  always @(negedge clk) begin
    if (!rst) begin
      if (resp_valid) begin
        n_resp++;
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("response at %0t with no request outstanding", $time);
        end else begin
          exp_resp = exp_q.pop_front();
          check_resp(resp, exp_resp, "response");
        end
      end else if (exp_q.size() != 0) begin
        check_bit(req_ready, 1'b0, "req_ready while busy");
      end
      if (req_valid && req_ready) begin  // transfers on the coming edge.
        exp_q.push_back(ref_access(req));
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog timeout after %0d ns, a request never completed", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int          err_mark;
    int          i;
    logic [31:0] r0;
    logic [31:0] a;
    lsu_size_e   sz;
    $timeformat(-9, 0, " ns", 0);
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    lcg_state = 32'h4cb9;
    n_checks  = 0;
    n_errors  = 0;
    n_resp    = 0;
    for (i = 0; i < MEM_WORDS * 4; i++) ref_mem[i] = 8'h00;
    repeat (3) @(posedge clk);
    #2 rst = 1'b0;

    err_mark = n_errors;
    repeat (3) begin
      @(negedge clk);
      check_bit(req_ready, 1'b1, "req_ready after reset");
      check_bit(resp_valid, 1'b0, "resp_valid after reset");
    end
    @(posedge clk);
    #2;
    report_test("reset state", err_mark);

    err_mark = n_errors;
    run_req(make_req(LSU_STORE, SIZE_WORD, 1'b0, 32'h0000_0000, 32'hcafe_f00d));
    run_req(make_req(LSU_LOAD, SIZE_WORD, 1'b0, 32'h0000_0000, 32'h0));
    run_req(make_req(LSU_STORE, SIZE_WORD, 1'b0, 32'h0000_03fc, 32'h8badf00d));
    run_req(make_req(LSU_LOAD, SIZE_WORD, 1'b0, 32'h0000_03fc, 32'h0));
    run_req(make_req(LSU_STORE, SIZE_WORD, 1'b0, 32'h0000_0010, 32'h0123_4567));
    run_req(make_req(LSU_LOAD, SIZE_WORD, 1'b1, 32'h0000_0010, 32'h0));
    report_test("word store and load", err_mark);

    err_mark = n_errors;
    for (i = 0; i < 4; i++) begin  // upper bits are junk.
      run_req(make_req(LSU_STORE, SIZE_BYTE, 1'b0, 32'h40 + i, 32'ha5a5_a53c + 32'h51 * i));
    end
    run_req(make_req(LSU_LOAD, SIZE_WORD, 1'b0, 32'h40, 32'h0));
    run_req(make_req(LSU_STORE, SIZE_HALF, 1'b0, 32'h44, 32'hdead_9a7e));
    run_req(make_req(LSU_STORE, SIZE_HALF, 1'b0, 32'h46, 32'hbeef_1c2d));
    run_req(make_req(LSU_LOAD, SIZE_WORD, 1'b0, 32'h44, 32'h0));
    run_req(make_req(LSU_STORE, SIZE_WORD, 1'b0, 32'h48, 32'h1122_3344));
    run_req(make_req(LSU_STORE, SIZE_BYTE, 1'b0, 32'h4a, 32'h0000_00ee));
    run_req(make_req(LSU_STORE, SIZE_HALF, 1'b0, 32'h48, 32'hffff_7755));
    run_req(make_req(LSU_LOAD, SIZE_WORD, 1'b0, 32'h48, 32'h0));
    report_test("partial store merge", err_mark);

    err_mark = n_errors;
    run_req(make_req(LSU_STORE, SIZE_WORD, 1'b0, 32'h80, 32'h80f7_7f81));
    for (i = 0; i < 8; i++) begin
      run_req(make_req(LSU_LOAD, SIZE_BYTE, i[0], 32'h80 + (i >> 1), 32'h0));
    end
    for (i = 0; i < 4; i++) begin
      run_req(make_req(LSU_LOAD, SIZE_HALF, i[0], 32'h80 + 2 * (i >> 1), 32'h0));
    end
    report_test("sign and zero extension", err_mark);

    err_mark = n_errors;
    n_resp = 0;
    send_req(make_req(LSU_STORE, SIZE_WORD, 1'b0, 32'h20, 32'h1234_5678));
    send_req(make_req(LSU_LOAD, SIZE_WORD, 1'b0, 32'h20, 32'h0));
    send_req(make_req(LSU_STORE, SIZE_BYTE, 1'b0, 32'h21, 32'h0000_00c3));
    send_req(make_req(LSU_LOAD, SIZE_HALF, 1'b1, 32'h20, 32'h0));
    req_valid = 1'b0;
    wait_resp();
    if (n_resp != 4) begin
      n_errors++;
      $display("held requests gave %0d responses, expected 4", n_resp);
    end
    report_test("back-pressure", err_mark);

    err_mark = n_errors;
    for (i = 0; i < RAND_REQS; i++) begin
      r0 = next_rand();
      a  = next_rand() & 32'hffff_fcff;  // 64-word window and wrapping high bits.
      sz = (r0[29:28] == 2'd3) ? SIZE_WORD : lsu_size_e'(r0[29:28]);
      if (sz == SIZE_HALF) a[0] = 1'b0;
      else if (sz == SIZE_WORD) a[1:0] = 2'b00;
      send_req(make_req(lsu_op_e'(r0[31]), sz, r0[30], a, next_rand()));
    end
    req_valid = 1'b0;
    wait_resp();
    report_test("random traffic", err_mark);

    if (exp_q.size() != 0) begin
      n_errors++;
      $display("%0d requests never received a response", exp_q.size());
    end
    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
